// File: riscv_mem_pkg.sv
package riscv_mem_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and sizes
    //////////////////////////////////////////////////////////////////////
    localparam int XLEN       = 32;  // Data and address width
    localparam int CTRL_W     = 12;  // Control word entering MEM
    localparam int WB_CTRL_W  = 8;   // Control bits kept past MEM
    localparam int REGADDR_W  = 5;   // x0..x31
    localparam int DMEM_WORDS = 256; // Data RAM depth in words
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS); // Word index, addr[9:2]

    //////////////////////////////////////////////////////////////////////
    // Control word layout as seen in MEM
    //////////////////////////////////////////////////////////////////////
    localparam int CTRL_WIDTH_LSB  = 0;  // funct3 style access width
    localparam int CTRL_WIDTH_MSB  = 2;
    localparam int CTRL_MEM_EN     = 3;  // Load or store in flight
    localparam int CTRL_WB_SRC_LSB = 4;  // Write-back source select
    localparam int CTRL_WB_SRC_MSB = 5;
    localparam int CTRL_RF_WE      = 6;  // Register write enable
    localparam int CTRL_RD_LSB     = 7;  // Destination register
    localparam int CTRL_RD_MSB     = 11;

    // Upper control bits carried into MEM/WB start at the wb source field
    localparam int WB_BASE    = CTRL_WB_SRC_LSB;
    localparam int WB_SRC_LSB = CTRL_WB_SRC_LSB - WB_BASE;
    localparam int WB_SRC_MSB = CTRL_WB_SRC_MSB - WB_BASE;
    localparam int WB_RF_WE   = CTRL_RF_WE - WB_BASE;
    localparam int WB_RD_LSB  = CTRL_RD_LSB - WB_BASE;
    localparam int WB_RD_MSB  = CTRL_RD_MSB - WB_BASE;

    // Access width, same codes as load/store funct3
    typedef enum logic [2:0] {
        MW_BYTE   = 3'b000, // lb / sb
        MW_HALF   = 3'b001, // lh / sh
        MW_WORD   = 3'b010, // lw / sw
        MW_BYTE_U = 3'b100, // lbu
        MW_HALF_U = 3'b101  // lhu
    } mem_width_e;

    // Source of the register file write data
    typedef enum logic [1:0] {
        WB_ALU  = 2'b00, // ALU result
        WB_LOAD = 2'b01, // Aligned load data
        WB_PC4  = 2'b10, // Link value, pc + 4
        WB_RSVD = 2'b11  // Illegal
    } wb_src_e;

endpackage

// File: data_memory.sv
`timescale 1ns/100ps

module data_memory import riscv_mem_pkg::*; (
    input  logic            clk,

    input  logic [XLEN-1:0] addr_i,      // Byte address
    input  logic [XLEN-1:0] wdata_i,     // Store data, right aligned
    input  mem_width_e      width_sel_i,
    input  logic            we_i,        // Store strobe

    output logic [XLEN-1:0] rdata_o      // Aligned and extended
);

    logic [XLEN-1:0]       mem [DMEM_WORDS]; // No reset on contents

    logic [DMEM_IDX_W-1:0] word_idx;
    logic [1:0]            byte_off;
    logic [3:0]            byte_en;
    logic [XLEN-1:0]       wdata_lane;
    logic [XLEN-1:0]       rd_word;
    logic [XLEN-1:0]       rd_shift;

    assign word_idx = addr_i[DMEM_IDX_W+1:2]; // addr[9:2]
    assign byte_off = addr_i[1:0];

    //////////////////////////////////////////////////////////////////////
    // Write path
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (width_sel_i)
            MW_BYTE, MW_BYTE_U: byte_en = 4'b0001 << byte_off;
            MW_HALF, MW_HALF_U: byte_en = 4'b0011 << {byte_off[1], 1'b0};
            MW_WORD:            byte_en = 4'b1111;
            default:            byte_en = 4'b0000; // Unknown width, no write
        endcase
    end

    // Move low data into the addressed lane
    assign wdata_lane = wdata_i << {byte_off, 3'b000};

    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[word_idx][b*8 +: 8] <= wdata_lane[b*8 +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read path, zero latency
    //////////////////////////////////////////////////////////////////////
    assign rd_word  = mem[word_idx];
    assign rd_shift = rd_word >> {byte_off, 3'b000}; // Lane down to bit 0

    always_comb begin
        case (width_sel_i)
            MW_BYTE:   rdata_o = {{(XLEN-8){rd_shift[7]}}, rd_shift[7:0]};    // Sign
            MW_BYTE_U: rdata_o = {{(XLEN-8){1'b0}}, rd_shift[7:0]};
            MW_HALF:   rdata_o = {{(XLEN-16){rd_shift[15]}}, rd_shift[15:0]}; // Sign
            MW_HALF_U: rdata_o = {{(XLEN-16){1'b0}}, rd_shift[15:0]};
            default:   rdata_o = rd_word; // Word access
        endcase
    end

    // Misaligned stores would split across words
    a_half_aligned: assert property (
        @(posedge clk)
        (we_i && (width_sel_i inside {MW_HALF, MW_HALF_U})) |-> (addr_i[0] == 1'b0)
    ) else $error("data_memory: misaligned halfword store");

    a_word_aligned: assert property (
        @(posedge clk)
        (we_i && width_sel_i == MW_WORD) |-> (addr_i[1:0] == 2'b00)
    ) else $error("data_memory: misaligned word store");

endmodule

// File: mem_stage.sv
`timescale 1ns/100ps

module mem_stage import riscv_mem_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,

    input  logic [XLEN-1:0]      execute_result_i, // ALU result or address
    input  logic [XLEN-1:0]      store_data_i,
    input  logic [CTRL_W-1:0]    control_signal_i,

    input  logic [XLEN-1:0]      load_data_i,      // From data memory

    input  logic                 trace_valid_i,
    input  logic [XLEN-1:0]      trace_pc_i,

    output logic [XLEN-1:0]      mem_addr_o,       // To data memory
    output logic [XLEN-1:0]      store_data_o,
    output mem_width_e           data_mem_width_sel_o,
    output logic                 data_mem_rw_o,

    output logic [REGADDR_W-1:0] fwd_dest_o,       // To forwarding unit
    output logic                 fwd_we_o,

    output logic [XLEN-1:0]      execute_result_o, // MEM/WB register
    output logic [XLEN-1:0]      load_data_o,
    output logic [WB_CTRL_W-1:0] control_signal_o,
    output logic                 trace_valid_o,
    output logic [XLEN-1:0]      trace_pc_o
);

    logic mem_en;
    logic rf_we;
    logic is_load;

    // Control word decode
    assign mem_en  = control_signal_i[CTRL_MEM_EN];
    assign rf_we   = control_signal_i[CTRL_RF_WE];
    assign is_load = mem_en & rf_we; // Load writes a register, store does not

    //////////////////////////////////////////////////////////////////////
    // Data memory side, combinational
    //////////////////////////////////////////////////////////////////////
    assign mem_addr_o           = execute_result_i;
    assign store_data_o         = store_data_i;
    assign data_mem_width_sel_o =
        mem_width_e'(control_signal_i[CTRL_WIDTH_MSB:CTRL_WIDTH_LSB]);
    assign data_mem_rw_o        = mem_en & ~rf_we; // Store strobe

    // Forwarding taps of the instruction now in MEM
    assign fwd_dest_o = control_signal_i[CTRL_RD_MSB:CTRL_RD_LSB];
    assign fwd_we_o   = rf_we;

    //////////////////////////////////////////////////////////////////////
    // MEM/WB pipeline register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            execute_result_o <= '0;
            load_data_o      <= '0;
            control_signal_o <= '0;
            trace_valid_o    <= 1'b0;
            trace_pc_o       <= '0;
        end else begin
            execute_result_o <= execute_result_i;
            // Read data only matters for a load, keep the rest quiet
            load_data_o      <= is_load ? load_data_i : '0;
            control_signal_o <= control_signal_i[CTRL_W-1:WB_BASE]; // Drop mem bits
            trace_valid_o    <= trace_valid_i;
            trace_pc_o       <= trace_pc_i;
        end
    end

    // A valid instruction must carry a fully known control word
    a_ctrl_known: assert property (
        @(posedge clk) disable iff (!reset)
        trace_valid_i |-> !$isunknown(control_signal_i)
    ) else $error("mem_stage: unknown control word on valid instruction");

endmodule

// File: writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage import riscv_mem_pkg::*; (
    input  logic [XLEN-1:0]      result_i,       // From MEM/WB register
    input  logic [XLEN-1:0]      load_data_i,
    input  logic [WB_CTRL_W-1:0] ctrl_i,
    input  logic                 trace_valid_i,
    input  logic [XLEN-1:0]      trace_pc_i,

    output logic                 rf_we_o,        // To register file
    output logic [REGADDR_W-1:0] rf_addr_o,
    output logic [XLEN-1:0]      rf_wdata_o,

    output logic                 retire_valid_o, // Retire report
    output logic [XLEN-1:0]      retire_pc_o
);

    wb_src_e              wb_src;
    logic                 wb_we;
    logic [REGADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]      link_value;

    //////////////////////////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////////////////////////
    assign wb_src = wb_src_e'(ctrl_i[WB_SRC_MSB:WB_SRC_LSB]);
    assign wb_we  = ctrl_i[WB_RF_WE];
    assign wb_rd  = ctrl_i[WB_RD_MSB:WB_RD_LSB];

    assign link_value = trace_pc_i + XLEN'(4); // jal / jalr return address

    // Write data select
    always_comb begin
        case (wb_src)
            WB_ALU:  rf_wdata_o = result_i;
            WB_LOAD: rf_wdata_o = load_data_i;
            WB_PC4:  rf_wdata_o = link_value;
            default: rf_wdata_o = '0; // Reserved code
        endcase
    end

    // x0 is hardwired, never written
    assign rf_we_o   = wb_we & (wb_rd != '0) & trace_valid_i;
    assign rf_addr_o = wb_rd;

    //////////////////////////////////////////////////////////////////////
    // Retire report
    //////////////////////////////////////////////////////////////////////
    assign retire_valid_o = trace_valid_i;
    assign retire_pc_o    = trace_pc_i;

    // Stage has no clock, so check once the time step settles
    always_comb begin
        a_no_rsvd_src: assert final (trace_valid_i !== 1'b1 || wb_src !== WB_RSVD)
        else $error("writeback_stage: reserved wb source on valid instruction");
    end

endmodule

// File: mem_wb_top.sv
`timescale 1ns/100ps

module mem_wb_top import riscv_mem_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,

    input  logic [XLEN-1:0]      execute_result_i,
    input  logic [XLEN-1:0]      store_data_i,
    input  logic [CTRL_W-1:0]    control_signal_i,
    input  logic                 trace_valid_i,
    input  logic [XLEN-1:0]      trace_pc_i,

    output logic [REGADDR_W-1:0] fwd_dest_o,
    output logic                 fwd_we_o,

    output logic                 rf_we_o,
    output logic [REGADDR_W-1:0] rf_addr_o,
    output logic [XLEN-1:0]      rf_wdata_o,

    output logic                 retire_valid_o,
    output logic [XLEN-1:0]      retire_pc_o
);

    // MEM <-> data memory
    logic [XLEN-1:0]      mem_addr;
    logic [XLEN-1:0]      data_mem_wdata;
    mem_width_e           data_mem_width_sel;
    logic                 data_mem_rw;
    logic [XLEN-1:0]      data_mem_rdata;

    // MEM/WB register outputs
    logic [XLEN-1:0]      wb_result;
    logic [XLEN-1:0]      wb_load_data;
    logic [WB_CTRL_W-1:0] wb_ctrl;
    logic                 wb_trace_valid;
    logic [XLEN-1:0]      wb_trace_pc;

    //////////////////////////////////////////////////////////////////////
    // Memory access stage
    //////////////////////////////////////////////////////////////////////
    mem_stage u_mem_stage (
        .clk                  (clk),
        .reset                (reset),
        .execute_result_i     (execute_result_i),
        .store_data_i         (store_data_i),
        .control_signal_i     (control_signal_i),
        .load_data_i          (data_mem_rdata),
        .trace_valid_i        (trace_valid_i),
        .trace_pc_i           (trace_pc_i),
        .mem_addr_o           (mem_addr),
        .store_data_o         (data_mem_wdata),
        .data_mem_width_sel_o (data_mem_width_sel),
        .data_mem_rw_o        (data_mem_rw),
        .fwd_dest_o           (fwd_dest_o),
        .fwd_we_o             (fwd_we_o),
        .execute_result_o     (wb_result),
        .load_data_o          (wb_load_data),
        .control_signal_o     (wb_ctrl),
        .trace_valid_o        (wb_trace_valid),
        .trace_pc_o           (wb_trace_pc)
    );

    data_memory u_data_memory (
        .clk         (clk),
        .addr_i      (mem_addr),
        .wdata_i     (data_mem_wdata),
        .width_sel_i (data_mem_width_sel),
        .we_i        (data_mem_rw),
        .rdata_o     (data_mem_rdata) // Combinational, back into MEM
    );

    //////////////////////////////////////////////////////////////////////
    // Write-back stage
    //////////////////////////////////////////////////////////////////////
    writeback_stage u_writeback_stage (
        .result_i       (wb_result),
        .load_data_i    (wb_load_data),
        .ctrl_i         (wb_ctrl),
        .trace_valid_i  (wb_trace_valid),
        .trace_pc_i     (wb_trace_pc),
        .rf_we_o        (rf_we_o),
        .rf_addr_o      (rf_addr_o),
        .rf_wdata_o     (rf_wdata_o),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o)
    );

endmodule

// File: tb_mem_wb_top.sv
`timescale 1ns/100ps

module tb_mem_wb_top import riscv_mem_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int MAX_VEC    = 64; // Room for the vector file
    localparam int N_GROUPS   = 8;

    // DUT inputs
    logic                 clk;
    logic                 reset;
    logic [XLEN-1:0]      execute_result_i;
    logic [XLEN-1:0]      store_data_i;
    logic [CTRL_W-1:0]    control_signal_i;
    logic                 trace_valid_i;
    logic [XLEN-1:0]      trace_pc_i;

    // DUT outputs
    logic [REGADDR_W-1:0] fwd_dest_o;
    logic                 fwd_we_o;
    logic                 rf_we_o;
    logic [REGADDR_W-1:0] rf_addr_o;
    logic [XLEN-1:0]      rf_wdata_o;
    logic                 retire_valid_o;
    logic [XLEN-1:0]      retire_pc_o;

    // Stimulus columns
    int                   v_grp    [MAX_VEC];
    logic [CTRL_W-1:0]    v_ctrl   [MAX_VEC];
    logic [XLEN-1:0]      v_result [MAX_VEC];
    logic [XLEN-1:0]      v_sdata  [MAX_VEC];
    logic [XLEN-1:0]      v_pc     [MAX_VEC];
    logic                 v_valid  [MAX_VEC];

    // Expected columns
    logic                 e_we     [MAX_VEC];
    logic [REGADDR_W-1:0] e_rd     [MAX_VEC];
    logic [XLEN-1:0]      e_wdata  [MAX_VEC];
    logic [REGADDR_W-1:0] e_fdest  [MAX_VEC];
    logic                 e_fwe    [MAX_VEC];

    int     n_vec;
    bit     loaded;
    integer seed;
    int     pass_count;
    int     fail_count;
    int     grp_pass [N_GROUPS];
    int     grp_fail [N_GROUPS];

    mem_wb_top DUT (
        .clk              (clk),
        .reset            (reset),
        .execute_result_i (execute_result_i),
        .store_data_i     (store_data_i),
        .control_signal_i (control_signal_i),
        .trace_valid_i    (trace_valid_i),
        .trace_pc_i       (trace_pc_i),
        .fwd_dest_o       (fwd_dest_o),
        .fwd_we_o         (fwd_we_o),
        .rf_we_o          (rf_we_o),
        .rf_addr_o        (rf_addr_o),
        .rf_wdata_o       (rf_wdata_o),
        .retire_valid_o   (retire_valid_o),
        .retire_pc_o      (retire_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk; // Rising edges at 5, 15, 25 ...
    end

    //////////////////////////////////////////////////////////////////////
    // Vector file and reporting helpers
    //////////////////////////////////////////////////////////////////////
    task automatic load_vectors();
        int          fd;
        int          cnt;
        string       line;
        int          grp, valid, we, rd, fdest, fwe;
        logic [31:0] ctrl, res, sd, pc, wd;
        fd = $fopen("mem_wb_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open mem_wb_vectors.txt");
        end else begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                line = "";
                cnt  = $fgets(line, fd);
                cnt  = $sscanf(line, "%d %h %h %h %h %d %d %d %h %d %d",
                               grp, ctrl, res, sd, pc, valid, we, rd, wd, fdest, fwe);
                if (cnt == 11) begin // Comment and blank lines fall out here
                    v_grp[n_vec]    = grp;
                    v_ctrl[n_vec]   = ctrl[CTRL_W-1:0];
                    v_result[n_vec] = res;
                    v_sdata[n_vec]  = sd;
                    v_pc[n_vec]     = pc;
                    v_valid[n_vec]  = valid[0];
                    e_we[n_vec]     = we[0];
                    e_rd[n_vec]     = rd[REGADDR_W-1:0];
                    e_wdata[n_vec]  = wd;
                    e_fdest[n_vec]  = fdest[REGADDR_W-1:0];
                    e_fwe[n_vec]    = fwe[0];
                    n_vec++;
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic string group_name(input int g);
        case (g)
            1:       return "reset";
            2:       return "alu write-back";
            3:       return "word store/load";
            4:       return "byte and halfword";
            5:       return "link and retire";
            6:       return "forwarding";
            default: return "misc";
        endcase
    endfunction

    task automatic compare_field(input string what, input logic [31:0] got,
                                 input logic [31:0] exp, input int grp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
            fail_count++;
            grp_fail[grp]++;
        end else begin
            pass_count++;
            grp_pass[grp]++;
        end
    endtask

    task automatic report_group(input int g);
        $display("Test %0d %s: %s (%0d checks, %0d wrong)", g, group_name(g),
                 (grp_fail[g] == 0) ? "ok" : "FAIL", grp_pass[g] + grp_fail[g], grp_fail[g]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Drive and check
    //////////////////////////////////////////////////////////////////////
    task automatic drive_line(input int i);
        execute_result_i = v_result[i];
        control_signal_i = v_ctrl[i];
        trace_valid_i    = v_valid[i];
        trace_pc_i       = v_pc[i];
        // Store data only reaches memory on a store
        if (v_ctrl[i][CTRL_MEM_EN] && !v_ctrl[i][CTRL_RF_WE]) begin
            store_data_i = v_sdata[i];
        end else begin
            store_data_i = $random(seed); // Filler, no effect on expected values
        end
    endtask

    task automatic drive_idle();
        execute_result_i = '0;
        store_data_i     = '0;
        control_signal_i = '0; // Bubble
        trace_valid_i    = 1'b0;
        trace_pc_i       = '0;
    endtask

    // Valid ALU write to x1, would show on rf_we_o if reset let it through
    task automatic drive_reset_traffic();
        execute_result_i = $random(seed);
        store_data_i     = '0;
        control_signal_i = '0;
        control_signal_i[CTRL_RF_WE]              = 1'b1;
        control_signal_i[CTRL_RD_MSB:CTRL_RD_LSB] = REGADDR_W'(1);
        trace_valid_i    = 1'b1;
        trace_pc_i       = 32'h0000_0040;
    endtask

    task automatic verify_forwarding(input int i);
        compare_field($sformatf("fwd_dest_o vector %0d", i), fwd_dest_o, e_fdest[i], v_grp[i]);
        compare_field($sformatf("fwd_we_o vector %0d", i), fwd_we_o, e_fwe[i], v_grp[i]);
    endtask

    // WB outputs now show the instruction driven one cycle earlier
    task automatic compare_writeback(input int k);
        compare_field($sformatf("rf_we_o vector %0d", k), rf_we_o, e_we[k], v_grp[k]);
        compare_field($sformatf("rf_addr_o vector %0d", k), rf_addr_o, e_rd[k], v_grp[k]);
        compare_field($sformatf("rf_wdata_o vector %0d", k), rf_wdata_o, e_wdata[k], v_grp[k]);
        compare_field($sformatf("retire_valid_o vector %0d", k), retire_valid_o,
                      v_valid[k], v_grp[k]);
        compare_field($sformatf("retire_pc_o vector %0d", k), retire_pc_o, v_pc[k], v_grp[k]);
    endtask

    task automatic expect_reset_quiet(input string phase);
        compare_field({"rf_we_o ", phase}, rf_we_o, 1'b0, 1);
        compare_field({"retire_valid_o ", phase}, retire_valid_o, 1'b0, 1);
    endtask

    task automatic run_sequence();
        int i;
        drive_reset_traffic(); // Live instruction sits at MEM while reset is low
        repeat (3) @(posedge clk); // Reset held for 3 cycles
        @(negedge clk);
        expect_reset_quiet("during reset");
        reset = 1'b1;
        for (i = 0; i < n_vec; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            drive_line(i);
            #(CLK_PERIOD/2 - 1); // Just ahead of the rising edge
            verify_forwarding(i);
            if (i == 0) begin
                expect_reset_quiet("after reset"); // MEM/WB not clocked yet
                report_group(1);
            end else begin
                compare_writeback(i - 1);
                if (v_grp[i] != v_grp[i-1]) begin
                    report_group(v_grp[i-1]);
                end
            end
        end
        @(negedge clk); // Drain the last instruction
        drive_idle();
        #(CLK_PERIOD/2 - 1);
        compare_writeback(n_vec - 1);
        report_group(v_grp[n_vec-1]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main flow and watchdog
    //////////////////////////////////////////////////////////////////////
    initial begin
        reset      = 1'b0;
        drive_idle();
        seed       = 96;
        n_vec      = 0;
        loaded     = 1'b0;
        pass_count = 0;
        fail_count = 0;
        for (int g = 0; g < N_GROUPS; g++) begin
            grp_pass[g] = 0;
            grp_fail[g] = 0;
        end
        load_vectors();
        loaded = 1'b1;
        if (n_vec == 0) begin
            $display("No usable vector lines were read, nothing was run");
            $display("CHECKS FAILED");
        end else begin
            run_sequence();
            $display("Summary: %0d checks ok, %0d checks wrong", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
        end
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        #((n_vec + 20) * CLK_PERIOD); // Vector lines plus margin
        $display("Timeout: run did not finish within %0d cycles", n_vec + 20);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: mem_wb_vectors.txt
// grp ctrl result sdata pc valid | rf_we rf_addr rf_wdata fwd_dest fwd_we (dec hex hex hex hex dec)
// grp 2 alu, 3 word ld/st, 4 byte/half, 5 link and retire, 6 forwarding; sdata used on stores only
2 2c0 00000011 00000000 00000100 1  1 5  00000011 5  1
2 540 a5a5a5a5 00000000 00000104 1  1 10 a5a5a5a5 10 1
2 040 ffffffff 00000000 00000108 1  0 0  ffffffff 0  1
2 fc0 80000000 00000000 0000010c 1  1 31 80000000 31 1
2 380 00000123 00000000 00000110 1  0 7  00000123 7  0
3 00a 00000100 deadbeef 00001000 1  0 0  00000100 0  0
3 35a 00000100 00000000 00001004 1  1 6  deadbeef 6  1
3 00a 00000104 12345678 00001008 1  0 0  00000104 0  0
3 3da 00000104 00000000 0000100c 1  1 7  12345678 7  1
3 35a 00000100 00000000 00001010 1  1 6  deadbeef 6  1
4 00a 00000200 11223344 00001100 1  0 0  00000200 0  0
4 008 00000201 ffffffa5 00001104 1  0 0  00000201 0  0
4 45a 00000200 00000000 00001108 1  1 8  1122a544 8  1
4 009 00000202 cafe8001 0000110c 1  0 0  00000202 0  0
4 45a 00000200 00000000 00001110 1  1 8  8001a544 8  1
4 4d8 00000201 00000000 00001114 1  1 9  ffffffa5 9  1
4 4dc 00000201 00000000 00001118 1  1 9  000000a5 9  1
4 4d8 00000200 00000000 0000111c 1  1 9  00000044 9  1
4 4d8 00000203 00000000 00001120 1  1 9  ffffff80 9  1
4 4dc 00000203 00000000 00001124 1  1 9  00000080 9  1
4 4d8 00000202 00000000 00001128 1  1 9  00000001 9  1
4 559 00000202 00000000 0000112c 1  1 10 ffff8001 10 1
4 55d 00000202 00000000 00001130 1  1 10 00008001 10 1
4 559 00000200 00000000 00001134 1  1 10 ffffa544 10 1
4 55d 00000200 00000000 00001138 1  1 10 0000a544 10 1
5 0e0 00003000 00000000 00002000 1  1 1  00002004 1  1
5 060 00003100 00000000 00002010 1  0 0  00002014 0  1
5 2e0 00000000 00000000 fffffffc 1  1 5  00000000 5  1
5 240 00000444 00000000 00002020 0  0 4  00000444 4  1
6 18a 00000108 0badf00d 00002100 1  0 3  00000108 3  0
6 fc0 7fffffff 00000000 00002104 1  1 31 7fffffff 31 1
6 600 00000555 00000000 00002108 1  0 12 00000555 12 0
6 15a 00000104 00000000 0000210c 1  1 2  12345678 2  1
6 000 00000000 00000000 00000000 0  0 0  00000000 0  0

// File: all.f
riscv_mem_pkg.sv
data_memory.sv
mem_stage.sv
writeback_stage.sv
mem_wb_top.sv
tb_mem_wb_top.sv

// File: Bender.yml
package:
  name: riscv_mem_wb

sources:
  - riscv_mem_pkg.sv
  - data_memory.sv
  - mem_stage.sv
  - writeback_stage.sv
  - mem_wb_top.sv
  - target: simulation
    files:
      - tb_mem_wb_top.sv
